//--- sim.f
hw/ex_pkg.sv
hw/redirect_if.sv
hw/alu.sv
hw/branch_unit.sv
hw/redirect_ctrl.sv
hw/misalign_check.sv
hw/ex_stage.sv
test/tb_ex_stage.sv

//--- Bender.yml
package:
  name: ex_stage

sources:
  - hw/ex_pkg.sv
  - hw/redirect_if.sv
  - hw/alu.sv
  - hw/branch_unit.sv
  - hw/redirect_ctrl.sv
  - hw/misalign_check.sv
  - hw/ex_stage.sv
  - target: test
    files:
      - test/tb_ex_stage.sv

//--- test/tb_ex_stage.sv
module tb_ex_stage;
    import ex_pkg::*;

    localparam int FLUSH_CYCLES  = 4;
    localparam int SQUASH_CYCLES = 6;
    localparam int N_RESET       = 8;
    localparam int N_RANDOM      = 3000;
    localparam int N_DIRECTED    = 24;
    localparam int WATCHDOG_TIME = (N_RESET + N_RANDOM + N_DIRECTED + 4) * 4 + 400;

    localparam alu_op_e OP_LIST [14] = '{alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and, alu_pass_a, alu_pass_b, alu_b_plus4,
        alu_idle};

    logic       CLK;
    logic       RST;
    logic       advance;
    logic       valid;
    word_t      a;
    word_t      b;
    alu_op_e    alu_op;
    logic       word_op;
    word_t      cmp_a;
    word_t      cmp_b;
    br_cond_e   cond;
    logic       branch;
    logic       jump;
    logic       jump_reg;
    logic       fence;
    word_t      pc;
    word_t      next_pc;
    word_t      jump_base;
    word_t      jump_offset;
    mem_op_e    mem_op;
    ldst_size_e ldst_size;
    word_t      result;
    logic       jump_final;
    word_t      jump_addr;
    logic       flush;
    logic       squash;
    logic       predicted;
    mem_op_e    mem_op_out;
    logic       fence_out;
    logic       word_op_out;
    logic       load_misaligned;
    logic       store_misaligned;

    integer     seed;
    int         flush_left;
    int         squash_left;
    logic       m_flush;
    logic       m_squash;
    word_t      exp_result;
    logic       exp_taken;
    word_t      exp_target;
    logic       exp_mis;
    logic       exp_ld_mis;
    logic       exp_st_mis;

    ex_stage #(
        .FLUSH_CYCLES  (FLUSH_CYCLES),
        .SQUASH_CYCLES (SQUASH_CYCLES)
    ) dut_i (.*);

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////
    function automatic word_t alu_ref(input word_t x, input word_t y, input alu_op_e op,
                                      input logic w);
        logic [31:0] lo;
        word_t       r;
        lo = 32'd0;
        case (op)
            alu_add:     r = y + x;
            alu_sub:     r = y - x;
            alu_sll:     r = y << x[5:0];
            alu_srl:     r = y >> x[5:0];
            alu_sra:     r = word_t'($signed(y) >>> x[5:0]);
            alu_slt:     r = {63'd0, $signed(y) < $signed(x)};
            alu_sltu:    r = {63'd0, y < x};
            alu_xor:     r = x ^ y;
            alu_or:      r = x | y;
            alu_and:     r = x & y;
            alu_pass_a:  r = x;
            alu_pass_b:  r = y;
            alu_b_plus4: r = y + 64'd4;
            default:     r = 64'd0;
        endcase
        if (w && (op == alu_add || op == alu_sub || op == alu_sll || op == alu_srl ||
                  op == alu_sra))
        begin
            case (op)
                alu_add: lo = y[31:0] + x[31:0];
                alu_sub: lo = y[31:0] - x[31:0];
                alu_sll: lo = y[31:0] << x[4:0];
                alu_srl: lo = y[31:0] >> x[4:0];
                default: lo = 32'($signed(y[31:0]) >>> x[4:0]);
            endcase
            r = {{32{lo[31]}}, lo};
        end
        return r;
    endfunction

    function automatic logic cond_ref(input word_t x, input word_t y, input br_cond_e c);
        case (c)
            br_eq:   return x == y;
            br_ne:   return x != y;
            br_lt:   return $signed(x) < $signed(y);
            br_ge:   return $signed(x) >= $signed(y);
            br_ltu:  return x < y;
            br_geu:  return x >= y;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic offset_bad(input logic [2:0] off, input ldst_size_e sz);
        if (sz == sz_half || sz == sz_uhalf)
            return off == 3'd7;
        if (sz == sz_word || sz == sz_uword)
            return off > 3'd4;
        if (sz == sz_double)
            return off != 3'd0;
        return 1'b0;
    endfunction

    assign m_flush    = flush_left != 0;
    assign m_squash   = squash_left != 0;
    assign exp_result = alu_ref(a, b, alu_op, word_op);
    assign exp_taken  = !m_squash && (fence || (branch ? cond_ref(cmp_a, cmp_b, cond)
                                                       : (jump || jump_reg)));
    assign exp_target = fence ? pc + 64'd4 : jump_base + jump_offset;
    assign exp_mis    = advance && (exp_taken ? (next_pc != exp_target || fence)
                                              : (valid && !m_squash && next_pc != pc + 64'd4));
    assign exp_ld_mis = mem_op == mem_load && offset_bad(exp_result[2:0], ldst_size);
    assign exp_st_mis = mem_op == mem_store && offset_bad(exp_result[2:0], ldst_size) &&
                        ldst_size != sz_uhalf && ldst_size != sz_uword;

    // Remaining advancing cycles of each window
    always @(posedge CLK)
    begin
        if (RST)
        begin
            flush_left  <= 0;
            squash_left <= 0;
        end
        else if (advance)
        begin
            if (exp_mis)
            begin
                flush_left  <= FLUSH_CYCLES;
                squash_left <= SQUASH_CYCLES;
            end
            else
            begin
                if (flush_left != 0)
                    flush_left <= flush_left - 1;
                if (squash_left != 0)
                    squash_left <= squash_left - 1;
            end
        end
    end

    task automatic report_failure(input string msg);
        $display("CHECK FAILED at time %0t: %s", $time, msg);
        $display("Regression failed");
        $fatal(1, "Stopping at the first error");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////
    a_result: assert property (@(posedge CLK) disable iff (RST) result == exp_result)
        else report_failure("ALU result differs from model");
    a_jump: assert property (@(posedge CLK) disable iff (RST) jump_final == exp_taken)
        else report_failure("jump_final differs from model");
    a_target: assert property (@(posedge CLK) disable iff (RST) jump_addr == exp_target)
        else report_failure("jump_addr differs from model");
    a_pred: assert property (@(posedge CLK) disable iff (RST) predicted == !exp_mis)
        else report_failure("predicted differs from model");
    a_flush: assert property (@(posedge CLK) disable iff (RST) flush == m_flush)
        else report_failure("flush differs from model");
    a_squash: assert property (@(posedge CLK) disable iff (RST) squash == m_squash)
        else report_failure("squash differs from model");
    a_strobes: assert property (@(posedge CLK) disable iff (RST)
        mem_op_out == (m_squash ? mem_none : mem_op) &&
        word_op_out == (word_op && !m_squash) &&
        fence_out == (fence && advance && !m_squash))
        else report_failure("masked strobe differs from model");
    a_quiet: assert property (@(posedge CLK) disable iff (RST)
        squash |-> !jump_final && mem_op_out == mem_none && !fence_out && !word_op_out)
        else report_failure("strobe active while squashed");
    a_misalign: assert property (@(posedge CLK) disable iff (RST)
        load_misaligned == exp_ld_mis && store_misaligned == exp_st_mis)
        else report_failure("misaligned flag differs from model");

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////
    task automatic drive_random();
        word_t base;
        word_t offs;
        word_t p;
        int    pick;
        @(posedge CLK);
        base = {$random(seed), $random(seed)};
        offs = {{52{1'b0}}, 12'($random(seed))};
        p    = {$random(seed), $random(seed) & 32'hffff_fffc};
        pick = $random(seed) & 3;
        a           <= {$random(seed), $random(seed)};
        b           <= {$random(seed), $random(seed)};
        alu_op      <= OP_LIST[$unsigned($random(seed)) % 14];
        word_op     <= 1'($random(seed));
        cmp_a       <= ($random(seed) & 3) == 0 ? 64'd5 : {$random(seed), $random(seed)};
        cmp_b       <= ($random(seed) & 3) == 0 ? 64'd5 : {$random(seed), $random(seed)};
        cond        <= br_cond_e'($random(seed) & 7);
        branch      <= 1'($random(seed));
        jump        <= ($random(seed) & 3) == 0;
        jump_reg    <= ($random(seed) & 3) == 0;
        fence       <= ($random(seed) & 15) == 0;
        advance     <= ($random(seed) & 3) != 0;
        valid       <= ($random(seed) & 7) != 0;
        pc          <= p;
        jump_base   <= base;
        jump_offset <= offs;
        // Mostly the sequential or jump path so some cycles predict correctly
        next_pc     <= pick < 2 ? p + 64'd4 : (pick == 2 ? base + offs : ~p);
        mem_op      <= mem_op_e'($unsigned($random(seed)) % 3);
        ldst_size   <= ldst_size_e'($unsigned($random(seed)) % 7);
    endtask

    // Fences with a stalling advance pattern
    task automatic drive_directed();
        for (int i = 0; i < N_DIRECTED; i++)
        begin
            @(posedge CLK);
            fence    <= (i % 12) == 0;
            advance  <= (i % 3) != 1;
            valid    <= 1'b1;
            branch   <= 1'b0;
            jump     <= 1'b0;
            jump_reg <= 1'b0;
            pc       <= 64'h1000;
            next_pc  <= 64'h1004;
            mem_op   <= mem_store;
            word_op  <= 1'b1;
        end
    endtask

    initial
    begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    initial
    begin
        #(WATCHDOG_TIME);
        $display("Timeout: the run did not finish within its cycle budget");
        $display("Regression failed");
        $fatal(1, "Watchdog expired");
    end

    initial
    begin
        seed        = 84419;
        RST         <= 1'b1;
        advance     <= 1'b0;
        valid       <= 1'b0;
        a           <= '0;
        b           <= '0;
        alu_op      <= alu_idle;
        word_op     <= 1'b0;
        cmp_a       <= '0;
        cmp_b       <= '0;
        cond        <= br_eq;
        branch      <= 1'b0;
        jump        <= 1'b0;
        jump_reg    <= 1'b0;
        fence       <= 1'b0;
        pc          <= '0;
        next_pc     <= 64'd4;
        jump_base   <= '0;
        jump_offset <= '0;
        mem_op      <= mem_none;
        ldst_size   <= sz_byte;
        repeat (N_RESET) @(posedge CLK);
        RST <= 1'b0;
        repeat (N_RANDOM) drive_random();
        drive_directed();
        repeat (2) @(posedge CLK);
        $display("Regression passed");
        $finish;
    end

endmodule

//--- hw/ex_stage.sv
module ex_stage #(
    parameter int FLUSH_CYCLES  = 4,
    parameter int SQUASH_CYCLES = 6
) (
    input  logic               CLK,
    input  logic               RST,
    input  logic               advance,
    input  logic               valid,
    input  ex_pkg::word_t      a,
    input  ex_pkg::word_t      b,
    input  ex_pkg::alu_op_e    alu_op,
    input  logic               word_op,
    input  ex_pkg::word_t      cmp_a,
    input  ex_pkg::word_t      cmp_b,
    input  ex_pkg::br_cond_e   cond,
    input  logic               branch,
    input  logic               jump,
    input  logic               jump_reg,
    input  logic               fence,
    input  ex_pkg::word_t      pc,
    input  ex_pkg::word_t      next_pc,
    input  ex_pkg::word_t      jump_base,
    input  ex_pkg::word_t      jump_offset,
    input  ex_pkg::mem_op_e    mem_op,
    input  ex_pkg::ldst_size_e ldst_size,
    output ex_pkg::word_t      result,
    output logic               jump_final,
    output ex_pkg::word_t      jump_addr,
    output logic               flush,
    output logic               squash,
    output logic               predicted,
    output ex_pkg::mem_op_e    mem_op_out,
    output logic               fence_out,
    output logic               word_op_out,
    output logic               load_misaligned,
    output logic               store_misaligned
);

    redirect_if rd ();

    alu alu_i (
        .a       (a),
        .b       (b),
        .op      (alu_op),
        .word_op (word_op),
        .result  (result)
    );

    branch_unit branch_i (
        .cmp_a       (cmp_a),
        .cmp_b       (cmp_b),
        .cond        (cond),
        .branch      (branch),
        .jump        (jump),
        .jump_reg    (jump_reg),
        .fence       (fence),
        .pc          (pc),
        .jump_base   (jump_base),
        .jump_offset (jump_offset),
        .rd          (rd.branch)
    );

    redirect_ctrl #(
        .FLUSH_CYCLES  (FLUSH_CYCLES),
        .SQUASH_CYCLES (SQUASH_CYCLES)
    ) redirect_i (
        .CLK         (CLK),
        .RST         (RST),
        .advance     (advance),
        .valid       (valid),
        .pc          (pc),
        .next_pc     (next_pc),
        .fence       (fence),
        .mem_op      (mem_op),
        .word_op     (word_op),
        .rd          (rd.ctrl),
        .flush       (flush),
        .predicted   (predicted),
        .mem_op_out  (mem_op_out),
        .fence_out   (fence_out),
        .word_op_out (word_op_out)
    );

    // ALU result doubles as the memory address
    misalign_check misalign_i (
        .addr             (result),
        .mem_op           (mem_op),
        .size             (ldst_size),
        .load_misaligned  (load_misaligned),
        .store_misaligned (store_misaligned)
    );

    assign jump_final = rd.jump_taken;
    assign jump_addr  = rd.jump_target;
    assign squash     = rd.squash;

endmodule

//--- hw/misalign_check.sv
module misalign_check (
    input  ex_pkg::word_t      addr,
    input  ex_pkg::mem_op_e    mem_op,
    input  ex_pkg::ldst_size_e size,
    output logic               load_misaligned,
    output logic               store_misaligned
);
    import ex_pkg::*;

    logic [2:0] offset;
    logic       half_mis;
    logic       word_mis;
    logic       dbl_mis;
    logic       ld_mis;
    logic       st_mis;

    assign offset   = addr[2:0];
    assign half_mis = &offset;
    assign word_mis = offset > 3'd4;
    assign dbl_mis  = |offset;

    // Unsigned forms exist only for loads
    always_comb
    begin
        ld_mis = 1'b0;
        st_mis = 1'b0;
        case (size)
            sz_half:   begin ld_mis = half_mis; st_mis = half_mis; end
            sz_uhalf:  ld_mis = half_mis;
            sz_word:   begin ld_mis = word_mis; st_mis = word_mis; end
            sz_uword:  ld_mis = word_mis;
            sz_double: begin ld_mis = dbl_mis; st_mis = dbl_mis; end
            default:   ld_mis = 1'b0;
        endcase
    end

    assign load_misaligned  = (mem_op == mem_load) & ld_mis;
    assign store_misaligned = (mem_op == mem_store) & st_mis;

    a_one_kind: assert final (!(load_misaligned === 1'b1 && store_misaligned === 1'b1))
        else $error("load and store misaligned together");

endmodule

//--- hw/redirect_ctrl.sv
module redirect_ctrl #(
    parameter int FLUSH_CYCLES  = 4,
    parameter int SQUASH_CYCLES = 6
) (
    input  logic            CLK,
    input  logic            RST,
    input  logic            advance,
    input  logic            valid,
    input  ex_pkg::word_t   pc,
    input  ex_pkg::word_t   next_pc,
    input  logic            fence,
    input  ex_pkg::mem_op_e mem_op,
    input  logic            word_op,
    redirect_if.ctrl        rd,
    output logic            flush,
    output logic            predicted,
    output ex_pkg::mem_op_e mem_op_out,
    output logic            fence_out,
    output logic            word_op_out
);
    import ex_pkg::*;

    localparam int MAX_CYCLES = (FLUSH_CYCLES > SQUASH_CYCLES) ? FLUSH_CYCLES : SQUASH_CYCLES;
    localparam int CNT_W = $clog2(MAX_CYCLES + 1);

    logic             mispredict;
    logic             squash_q;
    logic [CNT_W-1:0] flush_cnt;
    logic [CNT_W-1:0] squash_cnt;

    ////////////////////////////////////////////////////////////////////////////
    // Prediction check
    ////////////////////////////////////////////////////////////////////////////
    always_comb
    begin
        mispredict = 1'b0;
        if (advance)
        begin
            if (rd.jump_taken)
            begin
                mispredict = (next_pc != rd.jump_target) | rd.fence_redirect;
            end
            else if (valid && !squash_q)
            begin
                mispredict = next_pc != pc + word_t'(4);
            end
        end
    end

    assign predicted = ~mispredict;

    ////////////////////////////////////////////////////////////////////////////
    // Hold windows, frozen while the stage is held
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            flush      <= 1'b0;
            squash_q   <= 1'b0;
            flush_cnt  <= '0;
            squash_cnt <= '0;
        end
        else if (advance)
        begin
            if (mispredict)
            begin
                flush      <= 1'b1;
                squash_q   <= 1'b1;
                flush_cnt  <= '0;
                squash_cnt <= '0;
            end
            else
            begin
                if (flush)
                begin
                    if (flush_cnt == CNT_W'(FLUSH_CYCLES - 1))
                    begin
                        flush     <= 1'b0;
                        flush_cnt <= '0;
                    end
                    else
                    begin
                        flush_cnt <= flush_cnt + 1'b1;
                    end
                end
                if (squash_q)
                begin
                    if (squash_cnt == CNT_W'(SQUASH_CYCLES - 1))
                    begin
                        squash_q   <= 1'b0;
                        squash_cnt <= '0;
                    end
                    else
                    begin
                        squash_cnt <= squash_cnt + 1'b1;
                    end
                end
            end
        end
    end

    assign rd.squash = squash_q;

    // Outgoing strobes die while squashed
    assign mem_op_out  = squash_q ? mem_none : mem_op;
    assign word_op_out = word_op & ~squash_q;
    assign fence_out   = fence & ~squash_q & advance;

    a_flush_len: assert property (@(posedge CLK) disable iff (RST)
        $rose(flush) ##0 advance [->FLUSH_CYCLES] |=> !flush)
        else $error("flush held past its window");

    a_flush_in_squash: assert property (@(posedge CLK) disable iff (RST)
        flush |-> squash_q)
        else $error("flush without squash");

endmodule

//--- hw/branch_unit.sv
module branch_unit (
    input  ex_pkg::word_t    cmp_a,
    input  ex_pkg::word_t    cmp_b,
    input  ex_pkg::br_cond_e cond,
    input  logic             branch,
    input  logic             jump,
    input  logic             jump_reg,
    input  logic             fence,
    input  ex_pkg::word_t    pc,
    input  ex_pkg::word_t    jump_base,
    input  ex_pkg::word_t    jump_offset,
    redirect_if.branch       rd
);
    import ex_pkg::*;

    logic cond_true;
    logic taken_raw;

    always_comb
    begin
        case (cond)
            br_eq:   cond_true = cmp_a == cmp_b;
            br_ne:   cond_true = cmp_a != cmp_b;
            br_lt:   cond_true = $signed(cmp_a) < $signed(cmp_b);
            br_ge:   cond_true = $signed(cmp_a) >= $signed(cmp_b);
            br_ltu:  cond_true = cmp_a < cmp_b;
            br_geu:  cond_true = cmp_a >= cmp_b;
            default: cond_true = 1'b0;
        endcase
    end

    // Fence always redirects, to the next sequential PC
    always_comb
    begin
        if (fence)
        begin
            taken_raw = 1'b1;
        end
        else if (branch)
        begin
            taken_raw = cond_true;
        end
        else
        begin
            taken_raw = jump | jump_reg;
        end
    end

    assign rd.jump_taken     = taken_raw & ~rd.squash;
    assign rd.fence_redirect = fence & ~rd.squash;
    assign rd.jump_target    = fence ? pc + word_t'(4) : jump_base + jump_offset;

    // squash comes back from the redirect controller
    a_no_jump_in_squash: assert final (!(rd.jump_taken === 1'b1 && rd.squash === 1'b1))
        else $error("jump taken while squash active");

endmodule

//--- hw/alu.sv
module alu (
    input  ex_pkg::word_t   a,
    input  ex_pkg::word_t   b,
    input  ex_pkg::alu_op_e op,
    input  logic            word_op,
    output ex_pkg::word_t   result
);
    import ex_pkg::*;

    localparam int SHW = $clog2(XLEN);
    localparam int WSHW = $clog2(WLEN);

    logic [WLEN-1:0] add_w;
    logic [WLEN-1:0] sub_w;
    logic [WLEN-1:0] sll_w;
    logic [WLEN-1:0] srl_w;
    logic [WLEN-1:0] sra_w;
    logic            word_arith;

    function automatic word_t sext_w(input logic [WLEN-1:0] w);
        return {{(XLEN-WLEN){w[WLEN-1]}}, w};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Word mode results on the low half
    ////////////////////////////////////////////////////////////////////////////
    assign add_w = b[WLEN-1:0] + a[WLEN-1:0];
    assign sub_w = b[WLEN-1:0] - a[WLEN-1:0];
    assign sll_w = b[WLEN-1:0] << a[WSHW-1:0];
    assign srl_w = b[WLEN-1:0] >> a[WSHW-1:0];
    assign sra_w = $signed(b[WLEN-1:0]) >>> a[WSHW-1:0];

    // b is the first operand throughout
    always_comb
    begin
        case (op)
            alu_add:     result = word_op ? sext_w(add_w) : b + a;
            alu_sub:     result = word_op ? sext_w(sub_w) : b - a;
            alu_sll:     result = word_op ? sext_w(sll_w) : b << a[SHW-1:0];
            alu_srl:     result = word_op ? sext_w(srl_w) : b >> a[SHW-1:0];
            alu_sra:     result = word_op ? sext_w(sra_w) : word_t'($signed(b) >>> a[SHW-1:0]);
            alu_slt:     result = word_t'($signed(b) < $signed(a));
            alu_sltu:    result = word_t'(b < a);
            alu_xor:     result = a ^ b;
            alu_or:      result = a | b;
            alu_and:     result = a & b;
            alu_pass_a:  result = a;
            alu_pass_b:  result = b;
            alu_b_plus4: result = b + word_t'(4);
            default:     result = '0;
        endcase
    end

    assign word_arith = (word_op === 1'b1) &&
                        (op === alu_add || op === alu_sub || op === alu_sll ||
                         op === alu_srl || op === alu_sra);

    a_word_sext: assert final (!word_arith ||
                               result[XLEN-1:WLEN] === {(XLEN-WLEN){result[WLEN-1]}})
        else $error("word mode result not sign extended");

endmodule

//--- hw/redirect_if.sv
interface redirect_if;
    import ex_pkg::*;

    logic  jump_taken;
    word_t jump_target;
    logic  fence_redirect;
    logic  squash;

    modport branch (
        output jump_taken,
        output jump_target,
        output fence_redirect,
        input  squash
    );

    modport ctrl (
        input  jump_taken,
        input  jump_target,
        input  fence_redirect,
        output squash
    );

endinterface

//--- hw/ex_pkg.sv
package ex_pkg;

    localparam int XLEN = 64;
    localparam int WLEN = 32;

    typedef logic [XLEN-1:0] word_t;

    // ALU select, same code points as the decode stage drives
    typedef enum logic [3:0] {
        alu_add     = 4'd0,
        alu_sub     = 4'd1,
        alu_sll     = 4'd2,
        alu_slt     = 4'd3,
        alu_sltu    = 4'd4,
        alu_xor     = 4'd5,
        alu_srl     = 4'd6,
        alu_sra     = 4'd7,
        alu_or      = 4'd8,
        alu_and     = 4'd9,
        alu_pass_a  = 4'd10,
        alu_pass_b  = 4'd11,
        alu_b_plus4 = 4'd12,
        alu_idle    = 4'd15
    } alu_op_e;

    // Branch funct3, codes 2 and 3 never taken
    typedef enum logic [2:0] {
        br_eq  = 3'd0,
        br_ne  = 3'd1,
        br_lt  = 3'd4,
        br_ge  = 3'd5,
        br_ltu = 3'd6,
        br_geu = 3'd7
    } br_cond_e;

    typedef enum logic [1:0] {
        mem_none  = 2'd0,
        mem_load  = 2'd1,
        mem_store = 2'd2
    } mem_op_e;

    typedef enum logic [2:0] {
        sz_byte   = 3'd0,
        sz_half   = 3'd1,
        sz_word   = 3'd2,
        sz_double = 3'd3,
        sz_ubyte  = 3'd4,
        sz_uhalf  = 3'd5,
        sz_uword  = 3'd6
    } ldst_size_e;

endpackage
